// ==== mpf_csr_top.f ====
source/mmio_csr_pkg.sv
source/csr_read_if.sv
source/csr_read_queue.sv
source/feature_csr_regs.sv
source/mmio_rsp_fsm.sv
source/starvation_timer.sv
source/mpf_csr_top.sv
tb/tb_clock_gen.sv
tb/mpf_csr_sva.sv
tb/mpf_csr_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module mpf_csr_tb \
    --Mdir obj_dir -o mpf_csr_sim \
    -f mpf_csr_top.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/mpf_csr_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "STATUS: PASS" sim.log; then
    exit 0
else
    echo "Pass line not found in sim.log"
    exit 1
fi

// ==== source/csr_read_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// Head of the CSR read queue, offered to the response logic
interface csr_read_if;
    import mmio_csr_pkg::*;

    // High while the queue holds at least one read
    logic valid;

    // Word offset inside the window of the oldest read
    t_csr_offset offset;

    // Host transaction id that the response must carry
    t_mmio_tid tid;

    // The head entry leaves in a cycle where valid and take are both high
    logic take;

    modport producer (
        output valid,
        output offset,
        output tid,
        input take
    );

    modport consumer (
        input valid,
        input offset,
        input tid,
        output take
    );

endinterface

`default_nettype wire

// ==== source/csr_read_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

module csr_read_queue
(
    input wire clk,
    input wire reset_n,
    input wire req_valid,
    input wire req_write,
    input wire mmio_csr_pkg::t_mmio_addr req_addr,
    input wire mmio_csr_pkg::t_mmio_tid req_tid,
    csr_read_if.producer rd
);
    import mmio_csr_pkg::*;

    // Storage for queued reads, only the offset and tid are kept
    t_csr_offset offset_mem [csr_queue_depth];
    t_mmio_tid tid_mem [csr_queue_depth];

    // Pointers carry one extra wrap bit so a full queue differs from an empty one
    logic [queue_ptr_bits:0] wr_ptr;
    logic [queue_ptr_bits:0] rd_ptr;

    t_mmio_addr rel_addr;
    logic in_window;
    logic enq;
    logic deq;

    // ======================================================================
    // Window check
    // ======================================================================

    // Address relative to the window base
    assign rel_addr = req_addr - csr_base_word;

    // Below the base the subtraction wraps, so check the lower bound as well
    assign in_window = (req_addr >= csr_base_word) &&
                       (rel_addr < t_mmio_addr'(csr_window_words));

    // Only reads are queued, writes are decoded by the register block
    assign enq = req_valid && !req_write && in_window;
    assign deq = rd.valid && rd.take;

    // ======================================================================
    // Circular buffer
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (enq)
        begin
            offset_mem[wr_ptr[queue_ptr_bits-1:0]] <= t_csr_offset'(rel_addr);
            tid_mem[wr_ptr[queue_ptr_bits-1:0]] <= req_tid;
        end
    end

    // The host never has more than a full queue of reads in flight
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (enq)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Oldest entry is always presented, in request order
    assign rd.valid = (wr_ptr != rd_ptr);
    assign rd.offset = offset_mem[rd_ptr[queue_ptr_bits-1:0]];
    assign rd.tid = tid_mem[rd_ptr[queue_ptr_bits-1:0]];

endmodule

`default_nettype wire

// ==== source/feature_csr_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module feature_csr_regs
#(
    parameter bit vtp_enable = 1'b1,
    parameter bit wro_enable = 1'b1
)
(
    input wire clk,
    input wire reset_n,
    input wire req_valid,
    input wire req_write,
    input wire mmio_csr_pkg::t_mmio_addr req_addr,
    input wire mmio_csr_pkg::t_mmio_data req_data,
    input wire mmio_csr_pkg::t_csr_offset rd_offset,
    output mmio_csr_pkg::t_mmio_data rd_data,
    output mmio_csr_pkg::t_vtp_mode vtp_mode,
    output mmio_csr_pkg::t_mmio_data vtp_page_table_base,
    output logic vtp_page_table_base_valid
);
    import mmio_csr_pkg::*;

    t_dfh vtp_dfh;
    t_dfh wro_dfh;
    logic [127:0] vtp_uid_val;
    logic [127:0] wro_uid_val;

    // A 64 bit register may be written whole or as two 32 bit halves,
    // so the low word address bit is ignored for the match
    function automatic logic hits_word64(input t_mmio_addr addr, input int word_off);
        t_mmio_addr aligned;
        aligned = {addr[15:1], 1'b0};
        return aligned == (csr_base_word + t_mmio_addr'(word_off));
    endfunction

    // ======================================================================
    // Host writes to the VTP configuration
    // ======================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            vtp_mode <= '0;
            vtp_page_table_base <= '0;
            vtp_page_table_base_valid <= 1'b0;
        end
        else if (req_valid && req_write)
        begin
            if (hits_word64(req_addr, vtp_block_word + vtp_mode_word))
            begin
                vtp_mode <= t_vtp_mode'(req_data);
            end
            else if (hits_word64(req_addr, vtp_block_word + vtp_ptbase_word))
            begin
                vtp_page_table_base <= req_data;
                // The upper half of a split write arrives first, at the odd word,
                // and the update is only complete once the even word lands
                vtp_page_table_base_valid <= ~req_addr[0];
            end
        end
    end

    // ======================================================================
    // Feature headers
    // ======================================================================

    always_comb
    begin
        // VTP is first in the list and points at the WRO block
        vtp_dfh = '0;
        vtp_dfh.ftype = dfh_ftype_bbb;
        vtp_dfh.next = 24'(wro_block_word * 4);

        wro_dfh = '0;
        wro_dfh.ftype = dfh_ftype_bbb;
        if (csr_next_addr == 0)
        begin
            // Nothing follows, so WRO closes the feature list
            wro_dfh.next = 24'((wro_block_word + wro_block_words) * 4);
            wro_dfh.eol = 1'b1;
        end
        else
        begin
            wro_dfh.next = 24'(csr_next_addr);
        end
    end

    // A feature that is built out reports a null UID
    assign vtp_uid_val = vtp_enable ? vtp_uid : '0;
    assign wro_uid_val = wro_enable ? wro_uid : '0;

    // Read data for the offset at the head of the queue
    always_comb
    begin
        case (rd_offset)
            t_csr_offset'(vtp_block_word + dfh_word):        rd_data = vtp_dfh;
            t_csr_offset'(vtp_block_word + uid_l_word):      rd_data = vtp_uid_val[63:0];
            t_csr_offset'(vtp_block_word + uid_h_word):      rd_data = vtp_uid_val[127:64];
            t_csr_offset'(vtp_block_word + vtp_mode_word):   rd_data = t_mmio_data'(vtp_mode);
            t_csr_offset'(vtp_block_word + vtp_ptbase_word): rd_data = vtp_page_table_base;
            t_csr_offset'(wro_block_word + dfh_word):        rd_data = wro_dfh;
            t_csr_offset'(wro_block_word + uid_l_word):      rd_data = wro_uid_val[63:0];
            t_csr_offset'(wro_block_word + uid_h_word):      rd_data = wro_uid_val[127:64];
            // Unmapped words inside the window still answer, with zero
            default:                                         rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/mmio_csr_pkg.sv ====
`default_nettype none

package mmio_csr_pkg;

    // ======================================================================
    // Host MMIO request and response types
    // ======================================================================

    // Host word address, one step per 4 bytes
    typedef logic [15:0] t_mmio_addr;

    // Word offset from the start of the CSR window
    typedef logic [4:0] t_csr_offset;

    typedef logic [8:0] t_mmio_tid;
    typedef logic [63:0] t_mmio_data;

    // VTP translation mode register
    typedef logic [7:0] t_vtp_mode;

    // Device feature header, as seen by the host on a 64 bit read
    typedef struct packed {
        logic [3:0] ftype;
        logic [18:0] rsvd;
        logic eol;
        logic [23:0] next;
        logic [15:0] rev_id;
    } t_dfh;

    // Feature type for a building block
    localparam logic [3:0] dfh_ftype_bbb = 4'h2;

    // ======================================================================
    // CSR window layout
    // ======================================================================

    // Byte address of the window and of the feature that follows it
    localparam int csr_base_addr = 'h100;
    localparam int csr_next_addr = 0;
    localparam t_mmio_addr csr_base_word = t_mmio_addr'(csr_base_addr >> 2);

    // Each feature owns a block of 32 bit words
    localparam int vtp_block_word = 0;
    localparam int vtp_block_words = 16;
    localparam int wro_block_word = vtp_block_word + vtp_block_words;
    localparam int wro_block_words = 16;
    localparam int csr_window_words = vtp_block_words + wro_block_words;

    // Word offsets inside a block, all 64 bit aligned
    localparam int dfh_word = 0;
    localparam int uid_l_word = 2;
    localparam int uid_h_word = 4;
    localparam int vtp_mode_word = 6;
    localparam int vtp_ptbase_word = 8;

    // Read queue sizing and arbitration fairness
    localparam int csr_queue_depth = 16;
    localparam int queue_ptr_bits = $clog2(csr_queue_depth);
    localparam int starve_limit = 4;
    localparam int starve_count_bits = $clog2(starve_limit + 1);

    // Feature UIDs reported through the ID words
    localparam logic [127:0] vtp_uid = 128'hc8a2982f_ff96_42bf_a705_45727f501901;
    localparam logic [127:0] wro_uid = 128'h56b06b48_9dd7_4004_a47e_0681b4207a6d;

    // Source held in the response register
    typedef enum logic [1:0] {
        RSP_IDLE = 2'd0,
        RSP_USER = 2'd1,
        RSP_CSR = 2'd2
    } t_rsp_state;

endpackage

`default_nettype wire

// ==== source/mmio_rsp_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module mmio_rsp_fsm
(
    input wire clk,
    input wire reset_n,
    input wire user_rsp_valid,
    input wire mmio_csr_pkg::t_mmio_tid user_rsp_tid,
    input wire mmio_csr_pkg::t_mmio_data user_rsp_data,
    input wire mmio_csr_pkg::t_mmio_data rd_data,
    input wire hold,
    csr_read_if.consumer rd,
    output mmio_csr_pkg::t_csr_offset rd_offset,
    output logic csr_waiting,
    output logic user_won,
    output logic host_rsp_valid,
    output mmio_csr_pkg::t_mmio_tid host_rsp_tid,
    output mmio_csr_pkg::t_mmio_data host_rsp_data
);
    import mmio_csr_pkg::*;

    t_rsp_state rsp_state;
    t_rsp_state rsp_next;

    logic user_sel;
    logic csr_sel;

    // ======================================================================
    // Port arbitration
    // ======================================================================

    // User responses win unless the starvation timer holds them off
    assign user_sel = user_rsp_valid && !hold;
    assign csr_sel = rd.valid && !user_sel;

    // Dequeue exactly when the head read is loaded into the response register
    assign rd.take = csr_sel;
    assign rd_offset = rd.offset;

    // Status for the starvation timer
    assign csr_waiting = rd.valid;
    assign user_won = user_sel;

    always_comb
    begin
        rsp_next = RSP_IDLE;
        if (user_sel)
        begin
            rsp_next = RSP_USER;
        end
        else if (csr_sel)
        begin
            rsp_next = RSP_CSR;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rsp_state <= RSP_IDLE;
        end
        else
        begin
            rsp_state <= rsp_next;
        end
    end

    // ======================================================================
    // Response register
    // ======================================================================

    // User payloads pass through untouched, CSR reads take the decoded word
    always_ff @(posedge clk)
    begin
        if (user_sel)
        begin
            host_rsp_tid <= user_rsp_tid;
            host_rsp_data <= user_rsp_data;
        end
        else if (csr_sel)
        begin
            host_rsp_tid <= rd.tid;
            host_rsp_data <= rd_data;
        end
    end

    assign host_rsp_valid = (rsp_state != RSP_IDLE);

endmodule

`default_nettype wire

// ==== source/mpf_csr_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpf_csr_top
#(
    parameter bit vtp_enable = 1'b1,
    parameter bit wro_enable = 1'b1
)
(
    input wire clk,
    input wire reset_n,
    input wire host_req_valid,
    input wire host_req_write,
    input wire mmio_csr_pkg::t_mmio_addr host_req_addr,
    input wire mmio_csr_pkg::t_mmio_tid host_req_tid,
    input wire mmio_csr_pkg::t_mmio_data host_req_data,
    input wire user_rsp_valid,
    input wire mmio_csr_pkg::t_mmio_tid user_rsp_tid,
    input wire mmio_csr_pkg::t_mmio_data user_rsp_data,
    output logic user_rsp_ready,
    output logic host_rsp_valid,
    output mmio_csr_pkg::t_mmio_tid host_rsp_tid,
    output mmio_csr_pkg::t_mmio_data host_rsp_data,
    output mmio_csr_pkg::t_vtp_mode vtp_mode,
    output mmio_csr_pkg::t_mmio_data vtp_page_table_base,
    output logic vtp_page_table_base_valid
);
    import mmio_csr_pkg::*;

    // Head of the read queue toward the response logic
    csr_read_if rd_if ();

    t_csr_offset rd_offset;
    t_mmio_data rd_data;
    logic csr_waiting;
    logic user_won;
    logic hold;

    // In-window reads are buffered since the response port is shared
    csr_read_queue u_queue (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(host_req_valid),
        .req_write(host_req_write),
        .req_addr(host_req_addr),
        .req_tid(host_req_tid),
        .rd(rd_if.producer)
    );

    feature_csr_regs #(
        .vtp_enable(vtp_enable),
        .wro_enable(wro_enable)
    ) u_regs (
        .clk(clk),
        .reset_n(reset_n),
        .req_valid(host_req_valid),
        .req_write(host_req_write),
        .req_addr(host_req_addr),
        .req_data(host_req_data),
        .rd_offset(rd_offset),
        .rd_data(rd_data),
        .vtp_mode(vtp_mode),
        .vtp_page_table_base(vtp_page_table_base),
        .vtp_page_table_base_valid(vtp_page_table_base_valid)
    );

    mmio_rsp_fsm u_rsp (
        .clk(clk),
        .reset_n(reset_n),
        .user_rsp_valid(user_rsp_valid),
        .user_rsp_tid(user_rsp_tid),
        .user_rsp_data(user_rsp_data),
        .rd_data(rd_data),
        .hold(hold),
        .rd(rd_if.consumer),
        .rd_offset(rd_offset),
        .csr_waiting(csr_waiting),
        .user_won(user_won),
        .host_rsp_valid(host_rsp_valid),
        .host_rsp_tid(host_rsp_tid),
        .host_rsp_data(host_rsp_data)
    );

    starvation_timer u_timer (
        .clk(clk),
        .reset_n(reset_n),
        .csr_waiting(csr_waiting),
        .user_won(user_won),
        .hold(hold)
    );

    // The user is only ever stalled by the one cycle hold
    assign user_rsp_ready = ~hold;

endmodule

`default_nettype wire

// ==== source/starvation_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module starvation_timer
(
    input wire clk,
    input wire reset_n,
    input wire csr_waiting,
    input wire user_won,
    output logic hold
);
    import mmio_csr_pkg::*;

    // Cycles in a row that a pending CSR read lost the port to the user
    logic [starve_count_bits-1:0] starve_count;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            starve_count <= '0;
        end
        else if (!csr_waiting || !user_won)
        begin
            // Either nothing is waiting or the CSR read was just served
            starve_count <= '0;
        end
        else if (!hold)
        begin
            // Saturate at the limit, hold keeps the user off until the read goes
            starve_count <= starve_count + 1'b1;
        end
    end

    // One cycle of hold, since the CSR read is served in that same cycle
    // and the count then clears
    assign hold = (starve_count == starve_count_bits'(starve_limit));

endmodule

`default_nettype wire

// ==== tb/mpf_csr_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpf_csr_sva
(
    input wire clk,
    input wire reset_n,
    input wire host_req_valid,
    input wire host_req_write,
    input wire [15:0] host_req_addr,
    input wire csr_waiting,
    input wire user_won,
    input wire user_rsp_ready,
    input wire host_rsp_valid,
    input wire [8:0] host_rsp_tid,
    input wire [63:0] host_rsp_data,
    input wire [7:0] vtp_mode,
    input wire [63:0] vtp_page_table_base,
    input wire vtp_page_table_base_valid
);
    logic enq;
    logic deq;
    int outstanding;

    // Reads that enter the window and reads that get served
    assign enq = host_req_valid && !host_req_write &&
                 (host_req_addr >= 16'h40) && (host_req_addr < 16'h60);
    assign deq = csr_waiting && !user_won;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            outstanding <= 0;
        end
        else
        begin
            outstanding <= outstanding + int'(enq) - int'(deq);
        end
    end

    // Control outputs are always known once out of reset
    assert property (@(posedge clk) disable iff (!reset_n)
        !$isunknown({user_rsp_ready, host_rsp_valid, vtp_mode,
                     vtp_page_table_base, vtp_page_table_base_valid}))
        else $error("unknown value on a control output");

    // A valid response carries a known tid and payload
    assert property (@(posedge clk) disable iff (!reset_n)
        host_rsp_valid |-> !$isunknown({host_rsp_tid, host_rsp_data}))
        else $error("unknown tid or data on a valid response");

    // The user is stalled for single cycles only
    assert property (@(posedge clk) disable iff (!reset_n)
        !user_rsp_ready |=> user_rsp_ready)
        else $error("user_rsp_ready low for more than one cycle");

    assert property (@(posedge clk) disable iff (!reset_n)
        outstanding <= 16)
        else $error("more than 16 window reads outstanding");

endmodule

bind mpf_csr_top mpf_csr_sva u_sva (
    .clk(clk),
    .reset_n(reset_n),
    .host_req_valid(host_req_valid),
    .host_req_write(host_req_write),
    .host_req_addr(host_req_addr),
    .csr_waiting(csr_waiting),
    .user_won(user_won),
    .user_rsp_ready(user_rsp_ready),
    .host_rsp_valid(host_rsp_valid),
    .host_rsp_tid(host_rsp_tid),
    .host_rsp_data(host_rsp_data),
    .vtp_mode(vtp_mode),
    .vtp_page_table_base(vtp_page_table_base),
    .vtp_page_table_base_valid(vtp_page_table_base_valid)
);

`default_nettype wire

// ==== tb/mpf_csr_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module mpf_csr_tb;
    import mmio_csr_pkg::*;

    logic clk;
    logic reset_n;
    logic host_req_valid;
    logic host_req_write;
    t_mmio_addr host_req_addr;
    t_mmio_tid host_req_tid;
    t_mmio_data host_req_data;
    logic user_rsp_valid;
    t_mmio_tid user_rsp_tid;
    t_mmio_data user_rsp_data;
    logic user_rsp_ready;
    logic host_rsp_valid;
    t_mmio_tid host_rsp_tid;
    t_mmio_data host_rsp_data;
    t_vtp_mode vtp_mode;
    t_mmio_data vtp_page_table_base;
    logic vtp_page_table_base_valid;

    logic [31:0] lfsr = 32'h0dd1_90fa;
    logic [7:0] next_tid = 8'h0;
    logic [63:0] rnd;

    // Window words that hold a feature header or a UID half
    int feature_words[6] = '{0, 2, 4, 16, 18, 20};

    // Reads expected back, in request order
    t_mmio_tid exp_tid_q[$];
    t_mmio_data exp_data_q[$];

    // Register model and the user response taken at the last edge
    t_vtp_mode m_mode = '0;
    t_mmio_data m_base = '0;
    logic m_base_valid = 1'b0;
    logic user_taken = 1'b0;
    t_mmio_tid taken_tid;
    t_mmio_data taken_data;
    logic user_traffic = 1'b0;
    int miss_count = 0;
    int ops_issued = 0;
    int cycles = 0;

    tb_clock_gen u_clock (.clk(clk), .reset_n(reset_n));

    mpf_csr_top #(.vtp_enable(1'b1), .wro_enable(1'b1)) DUT (.*);

    // Galois LFSR, one step for each bit taken
    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
    endtask

    function automatic logic in_window(input t_mmio_addr a);
        return (a >= 16'h40) && (a < 16'h60);
    endfunction

    // Value a read of each window word must return
    function automatic t_mmio_data expected_word(input int off);
        case (off)
            0: return {4'h2, 19'd0, 1'b0, 24'h40, 16'd0};
            2: return vtp_uid[63:0];
            4: return vtp_uid[127:64];
            6: return {56'd0, m_mode};
            8: return m_base;
            16: return {4'h2, 19'd0, 1'b1, 24'h80, 16'd0};
            18: return wro_uid[63:0];
            20: return wro_uid[127:64];
            default: return '0;
        endcase
    endfunction

    task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("Fail %s got %h expected %h", name, got, exp);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_plain(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else fail_value(name, got, exp);
    endtask

    // ======================================================================
    // Monitor on the rising edge, builds the expected responses
    // ======================================================================

    always @(posedge clk)
    begin
        user_taken <= reset_n && user_rsp_valid && user_rsp_ready;
        taken_tid <= user_rsp_tid;
        taken_data <= user_rsp_data;
        if (reset_n && host_req_valid && host_req_write)
        begin
            if ({host_req_addr[15:1], 1'b0} == 16'h46)
                m_mode = host_req_data[7:0];
            else if ({host_req_addr[15:1], 1'b0} == 16'h48)
            begin
                m_base = host_req_data;
                m_base_valid = ~host_req_addr[0];
            end
        end
        else if (reset_n && host_req_valid && in_window(host_req_addr))
        begin
            exp_tid_q.push_back(host_req_tid);
            exp_data_q.push_back(expected_word(int'(host_req_addr - 16'h40)));
        end
    end

    // Response checks on the falling edge, where outputs are settled
    always @(negedge clk)
    begin
        if (reset_n)
        begin
            if (user_taken)
            begin
                assert (host_rsp_valid) else fail_plain("Accepted user response was dropped");
                check_eq("host_rsp_tid", host_rsp_tid, taken_tid);
                check_eq("host_rsp_data", host_rsp_data, taken_data);
            end
            else if (host_rsp_valid)
            begin
                assert (exp_tid_q.size() > 0) else fail_plain("Response with no read outstanding");
                check_eq("host_rsp_tid", host_rsp_tid, exp_tid_q.pop_front());
                check_eq("host_rsp_data", host_rsp_data, exp_data_q.pop_front());
                miss_count = 0;
            end
            if (exp_tid_q.size() > 0 && (user_taken || !host_rsp_valid))
            begin
                miss_count++;
                assert (miss_count <= starve_limit + 1)
                    else fail_plain("Pending CSR read starved by user traffic");
            end
        end
    end

    // Random user responses, held until the DUT takes them
    always @(negedge clk)
    begin
        if (!(user_rsp_valid && !user_taken))
        begin
            if (user_traffic)
            begin
                take_bits(8, rnd);
                user_rsp_tid = {1'b1, rnd[7:0]};
                take_bits(64, rnd);
                user_rsp_data = rnd;
                user_rsp_valid = 1'b1;
                ops_issued++;
            end
            else
            begin
                user_rsp_valid = 1'b0;
            end
        end
    end

    // Watchdog scaled by the number of operations issued so far
    always @(posedge clk)
    begin
        cycles++;
        if (cycles > 200 * ops_issued + 1000)
        begin
            $display("Timeout waiting for the DUT to respond");
            $display("STATUS: FAIL");
            $fatal(1, "watchdog expired");
        end
    end

    task automatic issue_read(input t_mmio_addr addr);
        @(negedge clk);
        host_req_valid = 1'b1;
        host_req_write = 1'b0;
        host_req_addr = addr;
        host_req_tid = {1'b0, next_tid};
        next_tid++;
        ops_issued++;
    endtask

    task automatic issue_write(input t_mmio_addr addr, input t_mmio_data data);
        @(negedge clk);
        host_req_valid = 1'b1;
        host_req_write = 1'b1;
        host_req_addr = addr;
        host_req_data = data;
        ops_issued++;
        @(negedge clk);
        host_req_valid = 1'b0;
        // The update is visible in the cycle after the write
        check_eq("vtp_mode", vtp_mode, m_mode);
        check_eq("vtp_page_table_base", vtp_page_table_base, m_base);
        check_eq("vtp_page_table_base_valid", vtp_page_table_base_valid, m_base_valid);
    endtask

    task automatic bus_idle();
        @(negedge clk);
        host_req_valid = 1'b0;
    endtask

    // Waits until every read and user response has come back
    task automatic drain();
        while (exp_tid_q.size() > 0 || user_rsp_valid || user_taken)
            @(negedge clk);
    endtask

    // With the port idle a read answers two cycles after its request
    task automatic idle_latency(input t_mmio_addr addr);
        t_mmio_tid tid;
        drain();
        issue_read(addr);
        tid = host_req_tid;
        bus_idle();
        assert (!host_rsp_valid) else fail_plain("Idle read answered one cycle early");
        @(negedge clk);
        assert (host_rsp_valid) else fail_plain("Idle read not answered after two cycles");
        check_eq("host_rsp_tid", host_rsp_tid, tid);
    endtask

    initial
    begin
        host_req_valid = 1'b0;
        host_req_write = 1'b0;
        host_req_addr = '0;
        host_req_tid = '0;
        host_req_data = '0;
        user_rsp_valid = 1'b0;
        user_rsp_tid = '0;
        user_rsp_data = '0;
        wait (reset_n);
        @(negedge clk);
        check_eq("host_rsp_valid", host_rsp_valid, 0);
        check_eq("user_rsp_ready", user_rsp_ready, 1);
        check_eq("vtp_mode", vtp_mode, 0);
        check_eq("vtp_page_table_base", vtp_page_table_base, 0);
        check_eq("vtp_page_table_base_valid", vtp_page_table_base_valid, 0);

        // ==================================================================
        // Register writes, then read them back
        // ==================================================================
        take_bits(64, rnd);
        issue_write(16'h46, rnd);
        take_bits(64, rnd);
        issue_write(16'h48, rnd);
        take_bits(64, rnd);
        issue_write(16'h49, rnd);
        take_bits(64, rnd);
        issue_write(16'h48, rnd);
        issue_read(16'h46);
        issue_read(16'h48);
        bus_idle();
        drain();

        // Feature headers and UIDs of both blocks
        foreach (feature_words[i])
            issue_read(16'h40 + t_mmio_addr'(feature_words[i]));
        bus_idle();
        drain();

        // ==================================================================
        // Window edges
        // ==================================================================
        issue_read(16'h3f);
        issue_read(16'h60);
        issue_read(16'h00);
        take_bits(16, rnd);
        issue_read(16'h8000 | rnd[15:0]);
        issue_read(16'h41);
        issue_read(16'h4a);
        issue_read(16'h5f);
        bus_idle();
        drain();
        repeat (10) @(negedge clk);
        idle_latency(16'h40);
        idle_latency(16'h53);

        // Reads mixed into continuous user traffic
        user_traffic = 1'b1;
        for (int i = 0; i < 12; i++)
        begin
            take_bits(5, rnd);
            issue_read(16'h40 + t_mmio_addr'(rnd[4:0]));
            bus_idle();
            take_bits(3, rnd);
            repeat (rnd[2:0]) @(negedge clk);
        end
        repeat (30) @(negedge clk);
        user_traffic = 1'b0;
        drain();

        // A full queue of back to back reads keeps request order
        for (int i = 0; i < 16; i++)
        begin
            take_bits(5, rnd);
            issue_read(16'h40 + t_mmio_addr'(rnd[4:0]));
        end
        bus_idle();
        drain();
        repeat (5) @(negedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

// Free running clock and a synchronous reset released after 16 cycles
module tb_clock_gen
(
    output logic clk,
    output logic reset_n
);
    localparam realtime half_period = 10ns;
    localparam int reset_cycles = 16;

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset changes on a falling edge, away from the sampling edge
    initial
    begin
        reset_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire
